/* Makefile */
# Verilator lint, simulation and clean

LOG = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing -f sources.f --top-module axi_mem_top

sim:
	verilator --binary --assert --timing -j 0 -f sources.f \
		--top-module tb_axi_mem -o tb_axi_mem
	./obj_dir/tb_axi_mem | tee $(LOG)
	grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* common/axi_mem_pkg.sv */
`default_nettype none

package axi_mem_pkg;

    // bus widths
    localparam int data_width = 32;
    localparam int strb_width = data_width / 8;
    localparam int addr_width = 32;
    localparam int len_width = 8;

    // side fields that are accepted but not acted on
    localparam int id_width = 4;
    localparam int size_width = 3;
    localparam int burst_width = 2;
    localparam int resp_width = 2;

    // byte offset bits inside one data word
    localparam int offset_width = $clog2(strb_width);

    // burst type and response codes
    localparam logic [burst_width-1:0] burst_incr = 2'b01;
    localparam logic [resp_width-1:0] resp_okay = 2'b00;

endpackage

`default_nettype wire

/* read_path/burst_counter.sv */
`default_nettype none

module burst_counter #(
    parameter int mem_index_width = 10
) (
    input  logic                                 clock,
    input  logic                                 reset,
    input  logic                                 burst_load,
    input  logic                                 burst_advance,
    input  logic [axi_mem_pkg::addr_width-1:0]   araddr,
    input  logic [axi_mem_pkg::len_width-1:0]    arlen,
    input  logic [axi_mem_pkg::burst_width-1:0]  arburst,
    output logic [mem_index_width-1:0]           ram_read_index,
    output logic                                 burst_last
);

    localparam int index_low = axi_mem_pkg::offset_width;
    localparam int index_high = index_low + mem_index_width - 1;

    logic [mem_index_width-1:0]         word_index;
    logic [mem_index_width-1:0]         next_index;
    logic [mem_index_width-1:0]         load_index;
    logic [axi_mem_pkg::len_width-1:0]  beats_left;

    wire unused_addr_bits = ^{araddr[axi_mem_pkg::addr_width-1:index_high+1],
                              araddr[index_low-1:0]};

    assign load_index = araddr[index_high:index_low];
    // wraps at the RAM depth
    assign next_index = word_index + 1'b1;

    always_ff @(posedge clock) begin
        if (reset) begin
            word_index <= '0;
            beats_left <= '0;
        end else if (burst_load) begin
            word_index <= load_index;
            beats_left <= (arburst == axi_mem_pkg::burst_incr) ? arlen : '0;
        end else if (burst_advance) begin
            word_index <= next_index;
            beats_left <= beats_left - 1'b1;
        end
    end

    assign ram_read_index = burst_load ? load_index : next_index;
    assign burst_last = (beats_left == '0);

endmodule

`default_nettype wire

/* read_path/read_fsm.sv */
`default_nettype none

module read_fsm (
    input  logic                                 clock,
    input  logic                                 reset,
    input  logic                                 arvalid,
    input  logic [axi_mem_pkg::burst_width-1:0]  arburst,
    input  logic                                 rready,
    input  logic                                 burst_last,
    output logic                                 arready,
    output logic                                 rvalid,
    output logic                                 rlast,
    output logic                                 burst_load,
    output logic                                 burst_advance,
    output logic                                 ram_read_enable
);

    localparam logic state_idle = 1'b0;
    localparam logic state_stream = 1'b1;

    logic state;

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= state_idle;
        end else if (burst_load) begin
            state <= state_stream;
        end else if (rvalid && rready && burst_last) begin
            state <= state_idle;
        end
    end

    assign arready = (state == state_idle);
    assign rvalid = (state == state_stream);
    assign rlast = rvalid && burst_last;

    // next word is fetched on the same edge as the handshake
    assign burst_load = arvalid && arready;
    assign burst_advance = rvalid && rready && !burst_last;
    assign ram_read_enable = burst_load || burst_advance;

    // stalled beat keeps its shape
    rvalid_stall_stable: assert property (@(posedge clock) disable iff (reset)
        rvalid && !rready |=> rvalid && $stable(rlast));

    // anything but INCR is a single beat
    single_beat_burst: assert property (@(posedge clock) disable iff (reset)
        burst_load && (arburst != axi_mem_pkg::burst_incr) |=> rlast);

endmodule

`default_nettype wire

/* source/axi_mem_top.sv */
`default_nettype none

module axi_mem_top #(
    parameter int mem_index_width = 10
) (
    input  logic                                   clock,
    input  logic                                   reset,

    input  logic                                   awvalid,
    input  logic [axi_mem_pkg::addr_width-1:0]     awaddr,
    input  logic [axi_mem_pkg::id_width-1:0]       awid,
    input  logic [axi_mem_pkg::len_width-1:0]      awlen,
    input  logic [axi_mem_pkg::size_width-1:0]     awsize,
    input  logic [axi_mem_pkg::burst_width-1:0]    awburst,
    output logic                                   awready,

    input  logic                                   wvalid,
    input  logic [axi_mem_pkg::data_width-1:0]     wdata,
    input  logic [axi_mem_pkg::strb_width-1:0]     wstrb,
    input  logic                                   wlast,
    output logic                                   wready,

    input  logic                                   bready,
    output logic                                   bvalid,
    output logic [axi_mem_pkg::id_width-1:0]       bid,
    output logic [axi_mem_pkg::resp_width-1:0]     bresp,

    input  logic                                   arvalid,
    input  logic [axi_mem_pkg::addr_width-1:0]     araddr,
    input  logic [axi_mem_pkg::id_width-1:0]       arid,
    input  logic [axi_mem_pkg::len_width-1:0]      arlen,
    input  logic [axi_mem_pkg::size_width-1:0]     arsize,
    input  logic [axi_mem_pkg::burst_width-1:0]    arburst,
    output logic                                   arready,

    input  logic                                   rready,
    output logic                                   rvalid,
    output logic [axi_mem_pkg::data_width-1:0]     rdata,
    output logic [axi_mem_pkg::id_width-1:0]       rid,
    output logic [axi_mem_pkg::resp_width-1:0]     rresp,
    output logic                                   rlast
);

    logic                                ram_write_enable;
    logic [mem_index_width-1:0]          ram_write_index;
    logic [axi_mem_pkg::data_width-1:0]  ram_write_data;
    logic [axi_mem_pkg::strb_width-1:0]  ram_write_strb;
    logic                                ram_read_enable;
    logic [mem_index_width-1:0]          ram_read_index;
    logic                                burst_load;
    logic                                burst_advance;
    logic                                burst_last;

    // writes are single beat, so length, size and last are ignored
    wire unused_inputs = ^{awid, awlen, awsize, awburst, wlast, arid, arsize};

    // no ids and no error responses
    assign bid = '0;
    assign rid = '0;
    assign bresp = axi_mem_pkg::resp_okay;
    assign rresp = axi_mem_pkg::resp_okay;

    write_fsm #(
        .mem_index_width (mem_index_width)
    ) write_fsm_inst (
        .clock            (clock),
        .reset            (reset),
        .awvalid          (awvalid),
        .awaddr           (awaddr),
        .wvalid           (wvalid),
        .wdata            (wdata),
        .wstrb            (wstrb),
        .bready           (bready),
        .awready          (awready),
        .wready           (wready),
        .bvalid           (bvalid),
        .ram_write_enable (ram_write_enable),
        .ram_write_index  (ram_write_index),
        .ram_write_data   (ram_write_data),
        .ram_write_strb   (ram_write_strb)
    );

    read_fsm read_fsm_inst (
        .clock           (clock),
        .reset           (reset),
        .arvalid         (arvalid),
        .arburst         (arburst),
        .rready          (rready),
        .burst_last      (burst_last),
        .arready         (arready),
        .rvalid          (rvalid),
        .rlast           (rlast),
        .burst_load      (burst_load),
        .burst_advance   (burst_advance),
        .ram_read_enable (ram_read_enable)
    );

    burst_counter #(
        .mem_index_width (mem_index_width)
    ) burst_counter_inst (
        .clock          (clock),
        .reset          (reset),
        .burst_load     (burst_load),
        .burst_advance  (burst_advance),
        .araddr         (araddr),
        .arlen          (arlen),
        .arburst        (arburst),
        .ram_read_index (ram_read_index),
        .burst_last     (burst_last)
    );

    // read register drives rdata directly
    word_ram #(
        .mem_index_width (mem_index_width)
    ) word_ram_inst (
        .clock            (clock),
        .ram_write_enable (ram_write_enable),
        .ram_write_index  (ram_write_index),
        .ram_write_data   (ram_write_data),
        .ram_write_strb   (ram_write_strb),
        .ram_read_enable  (ram_read_enable),
        .ram_read_index   (ram_read_index),
        .ram_read_data    (rdata)
    );

endmodule

`default_nettype wire

/* source/word_ram.sv */
`default_nettype none

module word_ram #(
    parameter int mem_index_width = 10
) (
    input  logic                                clock,
    input  logic                                ram_write_enable,
    input  logic [mem_index_width-1:0]          ram_write_index,
    input  logic [axi_mem_pkg::data_width-1:0]  ram_write_data,
    input  logic [axi_mem_pkg::strb_width-1:0]  ram_write_strb,
    input  logic                                ram_read_enable,
    input  logic [mem_index_width-1:0]          ram_read_index,
    output logic [axi_mem_pkg::data_width-1:0]  ram_read_data
);

    localparam int depth = 2 ** mem_index_width;

    logic [axi_mem_pkg::data_width-1:0] mem [depth];

    // one byte lane per strobe bit
    always_ff @(posedge clock) begin
        if (ram_write_enable) begin
            for (int lane = 0; lane < axi_mem_pkg::strb_width; lane++) begin
                if (ram_write_strb[lane]) begin
                    mem[ram_write_index][lane*8 +: 8] <= ram_write_data[lane*8 +: 8];
                end
            end
        end
    end

    // holds while not enabled, so a stalled beat keeps its data.
    // A same-edge write to this word is seen only on the next read.
    always_ff @(posedge clock) begin
        if (ram_read_enable) begin
            ram_read_data <= mem[ram_read_index];
        end
    end

endmodule

`default_nettype wire

/* sources.f */
common/axi_mem_pkg.sv
source/word_ram.sv
write_path/write_fsm.sv
read_path/burst_counter.sv
read_path/read_fsm.sv
source/axi_mem_top.sv
testbench/tb_axi_mem.sv

/* testbench/tb_axi_mem.sv */
`default_nettype none

module tb_axi_mem;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int mem_index_width = 10;
    localparam int depth = 2 ** mem_index_width;
    localparam int num_rows = 18;
    localparam int cycles_per_row = 40;
    localparam int reset_cycles = 2;

    logic                                   clock;
    logic                                   reset;
    logic                                   awvalid;
    logic [axi_mem_pkg::addr_width-1:0]     awaddr;
    logic [axi_mem_pkg::id_width-1:0]       awid;
    logic [axi_mem_pkg::len_width-1:0]      awlen;
    logic [axi_mem_pkg::size_width-1:0]     awsize;
    logic [axi_mem_pkg::burst_width-1:0]    awburst;
    logic                                   awready;
    logic                                   wvalid;
    logic [axi_mem_pkg::data_width-1:0]     wdata;
    logic [axi_mem_pkg::strb_width-1:0]     wstrb;
    logic                                   wlast;
    logic                                   wready;
    logic                                   bready;
    logic                                   bvalid;
    logic [axi_mem_pkg::id_width-1:0]       bid;
    logic [axi_mem_pkg::resp_width-1:0]     bresp;
    logic                                   arvalid;
    logic [axi_mem_pkg::addr_width-1:0]     araddr;
    logic [axi_mem_pkg::id_width-1:0]       arid;
    logic [axi_mem_pkg::len_width-1:0]      arlen;
    logic [axi_mem_pkg::size_width-1:0]     arsize;
    logic [axi_mem_pkg::burst_width-1:0]    arburst;
    logic                                   arready;
    logic                                   rready;
    logic                                   rvalid;
    logic [axi_mem_pkg::data_width-1:0]     rdata;
    logic [axi_mem_pkg::id_width-1:0]       rid;
    logic [axi_mem_pkg::resp_width-1:0]     rresp;
    logic                                   rlast;

    // one row per AXI operation
    bit                                     op_write [num_rows];
    logic [axi_mem_pkg::addr_width-1:0]     op_addr [num_rows];
    logic [axi_mem_pkg::data_width-1:0]     op_data [num_rows];
    logic [axi_mem_pkg::strb_width-1:0]     op_strb [num_rows];
    logic [axi_mem_pkg::len_width-1:0]      op_len [num_rows];
    logic [axi_mem_pkg::burst_width-1:0]    op_burst [num_rows];
    bit                                     op_stall [num_rows];
    string                                  op_name [num_rows];

    logic [axi_mem_pkg::data_width-1:0]     model_mem [depth];
    integer                                 seed = 32'ha8f0;

    axi_mem_top #(
        .mem_index_width (mem_index_width)
    ) axi_mem_top_inst (
        .clock   (clock),
        .reset   (reset),
        .awvalid (awvalid),
        .awaddr  (awaddr),
        .awid    (awid),
        .awlen   (awlen),
        .awsize  (awsize),
        .awburst (awburst),
        .awready (awready),
        .wvalid  (wvalid),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wlast   (wlast),
        .wready  (wready),
        .bready  (bready),
        .bvalid  (bvalid),
        .bid     (bid),
        .bresp   (bresp),
        .arvalid (arvalid),
        .araddr  (araddr),
        .arid    (arid),
        .arlen   (arlen),
        .arsize  (arsize),
        .arburst (arburst),
        .arready (arready),
        .rready  (rready),
        .rvalid  (rvalid),
        .rdata   (rdata),
        .rid     (rid),
        .rresp   (rresp),
        .rlast   (rlast)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string test, input string field,
                                   input logic [31:0] expected, input logic [31:0] actual);
        $display("mismatch %s %s: expected %h, actual %h", test, field, expected, actual);
        stop_with_failure("read beat does not match the expected value");
    endtask

    task automatic set_row(input int i, input bit write, input logic [31:0] addr,
                           input logic [31:0] data, input logic [3:0] strb,
                           input logic [7:0] len, input logic [1:0] burst,
                           input bit stall, input string name);
        op_write[i] = write;
        op_addr[i] = addr;
        op_data[i] = data;
        op_strb[i] = strb;
        op_len[i] = len;
        op_burst[i] = burst;
        op_stall[i] = stall;
        op_name[i] = name;
    endtask

    task automatic fill_table();
        set_row(0, 1, 32'h000, 32'h1111_1111, 4'hf, 8'd0, 2'b01, 0, "write_word0");
        set_row(1, 1, 32'h004, 32'h2222_2222, 4'hf, 8'd0, 2'b01, 0, "write_word1");
        set_row(2, 1, 32'h008, 32'h3333_3333, 4'hf, 8'd0, 2'b01, 0, "write_word2");
        set_row(3, 1, 32'h00c, 32'h4444_4444, 4'hf, 8'd0, 2'b01, 0, "write_word3");
        set_row(4, 0, 32'h000, 32'h0, 4'h0, 8'd0, 2'b01, 0, "read_word0");
        set_row(5, 0, 32'h004, 32'h0, 4'h0, 8'd0, 2'b01, 0, "read_word1");
        set_row(6, 1, 32'h008, 32'haabb_ccdd, 4'b0101, 8'd0, 2'b01, 0, "strobe_word2");
        set_row(7, 1, 32'h00c, 32'h5566_7788, 4'b1010, 8'd0, 2'b01, 1, "strobe_word3_bstall");
        set_row(8, 0, 32'h008, 32'h0, 4'h0, 8'd0, 2'b01, 0, "read_strobed_word2");
        set_row(9, 0, 32'h00c, 32'h0, 4'h0, 8'd0, 2'b01, 0, "read_strobed_word3");
        set_row(10, 0, 32'h000, 32'h0, 4'h0, 8'd3, 2'b01, 0, "incr_burst_4");
        set_row(11, 0, 32'h004, 32'h0, 4'h0, 8'd2, 2'b01, 1, "incr_burst_3_rstall");
        set_row(12, 0, 32'h004, 32'h0, 4'h0, 8'd5, 2'b00, 0, "fixed_single_beat");
        set_row(13, 0, 32'h008, 32'h0, 4'h0, 8'd3, 2'b10, 1, "wrap_single_beat");
        set_row(14, 1, 32'hffc, 32'h9988_7766, 4'hf, 8'd0, 2'b01, 1, "write_top_word");
        // 0x1010 lands on word 4 once the address wraps at the RAM depth
        set_row(15, 1, 32'h1010, 32'hcafe_f00d, 4'hf, 8'd0, 2'b01, 0, "write_alias_word4");
        set_row(16, 0, 32'hffc, 32'h0, 4'h0, 8'd4, 2'b01, 1, "incr_burst_wrap_rstall");
        set_row(17, 0, 32'h010, 32'h0, 4'h0, 8'd0, 2'b01, 0, "read_alias_word4");
    endtask

    function automatic int word_index(input logic [31:0] addr, input int beat);
        return int'(((addr >> 2) + beat) % depth);
    endfunction

    task automatic update_model(input logic [31:0] addr, input logic [31:0] data,
                                input logic [3:0] strb);
        int idx;
        idx = word_index(addr, 0);
        for (int lane = 0; lane < axi_mem_pkg::strb_width; lane++) begin
            if (strb[lane]) begin
                model_mem[idx][lane*8 +: 8] = data[lane*8 +: 8];
            end
        end
    endtask

    // enters and leaves just after a falling edge
    task automatic write_single(input int i);
        int stall_cycles;
        awvalid = 1'b1;
        awaddr = op_addr[i];
        while (awready !== 1'b1) @(negedge clock);
        @(negedge clock);
        awvalid = 1'b0;
        assert (awready === 1'b0 && wready === 1'b1) else
            stop_with_failure({op_name[i], ": aw handshake did not open the w channel"});
        wvalid = 1'b1;
        wdata = op_data[i];
        wstrb = op_strb[i];
        @(negedge clock);
        wvalid = 1'b0;
        assert (wready === 1'b0 && bvalid === 1'b1) else
            stop_with_failure({op_name[i], ": no write response after the w handshake"});
        update_model(op_addr[i], op_data[i], op_strb[i]);
        stall_cycles = op_stall[i] ? int'({$random(seed)} % 32'd4) : 0;
        repeat (stall_cycles) begin
            assert (bvalid === 1'b1 && awready === 1'b0) else
                stop_with_failure({op_name[i], ": bvalid fell or awready rose before bready"});
            @(negedge clock);
        end
        bready = 1'b1;
        @(negedge clock);
        bready = 1'b0;
        assert (awready === 1'b1) else
            stop_with_failure({op_name[i], ": awready did not return after the b handshake"});
    endtask

    task automatic read_burst(input int i);
        int beats;
        int stall_cycles;
        logic [31:0] expected;
        logic expected_last;
        logic [31:0] held_data;
        logic held_last;
        beats = (op_burst[i] == axi_mem_pkg::burst_incr) ? int'(op_len[i]) + 1 : 1;
        arvalid = 1'b1;
        araddr = op_addr[i];
        arlen = op_len[i];
        arburst = op_burst[i];
        while (arready !== 1'b1) @(negedge clock);
        @(negedge clock);
        arvalid = 1'b0;
        for (int beat = 0; beat < beats; beat++) begin
            expected = model_mem[word_index(op_addr[i], beat)];
            expected_last = (beat == beats - 1);
            stall_cycles = op_stall[i] ? int'({$random(seed)} % 32'd4) : 0;
            if (stall_cycles > 0) begin
                rready = 1'b0;
                held_data = rdata;
                held_last = rlast;
                repeat (stall_cycles) begin
                    @(negedge clock);
                    assert (rvalid === 1'b1 && rdata === held_data && rlast === held_last) else
                        stop_with_failure({op_name[i], ": held read beat changed during stall"});
                end
            end
            rready = 1'b1;
            assert (rvalid === 1'b1 && arready === 1'b0) else
                stop_with_failure({op_name[i], ": no read beat where one was due"});
            assert (rdata === expected) else
                report_mismatch(op_name[i], "rdata", expected, rdata);
            assert (rlast === expected_last) else
                report_mismatch(op_name[i], "rlast", {31'd0, expected_last}, {31'd0, rlast});
            @(negedge clock);
        end
        rready = 1'b0;
        assert (rvalid === 1'b0 && arready === 1'b1) else
            stop_with_failure({op_name[i], ": extra read beat or arready not back after rlast"});
    endtask

    // side channels never change
    always @(negedge clock) begin
        if (!reset) begin
            assert (bresp === axi_mem_pkg::resp_okay && rresp === axi_mem_pkg::resp_okay
                    && bid === '0 && rid === '0) else
                stop_with_failure("response code is not OKAY or an id is not zero");
        end
    end

    initial begin
        repeat (reset_cycles + 2 + num_rows * cycles_per_row) @(posedge clock);
        stop_with_failure("timeout: an AXI handshake hung and the operations did not finish");
    end

    initial begin
        reset = 1'b1;
        awvalid = 1'b0;
        awaddr = '0;
        awid = '0;
        awlen = '0;
        awsize = 3'd2;
        awburst = axi_mem_pkg::burst_incr;
        wvalid = 1'b0;
        wdata = '0;
        wstrb = '0;
        wlast = 1'b1;
        bready = 1'b0;
        arvalid = 1'b0;
        araddr = '0;
        arid = '0;
        arlen = '0;
        arsize = 3'd2;
        arburst = axi_mem_pkg::burst_incr;
        rready = 1'b0;
        fill_table();
        repeat (reset_cycles) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        @(negedge clock);
        assert (awready === 1'b1 && arready === 1'b1 && wready === 1'b0
                && bvalid === 1'b0 && rvalid === 1'b0) else
            stop_with_failure("handshake outputs are not in their reset state");
        for (int i = 0; i < num_rows; i++) begin
            if (op_write[i]) begin
                write_single(i);
            end else begin
                read_burst(i);
            end
        end
        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* write_path/write_fsm.sv */
`default_nettype none

module write_fsm #(
    parameter int mem_index_width = 10
) (
    input  logic                                clock,
    input  logic                                reset,
    input  logic                                awvalid,
    input  logic [axi_mem_pkg::addr_width-1:0]  awaddr,
    input  logic                                wvalid,
    input  logic [axi_mem_pkg::data_width-1:0]  wdata,
    input  logic [axi_mem_pkg::strb_width-1:0]  wstrb,
    input  logic                                bready,
    output logic                                awready,
    output logic                                wready,
    output logic                                bvalid,
    output logic                                ram_write_enable,
    output logic [mem_index_width-1:0]          ram_write_index,
    output logic [axi_mem_pkg::data_width-1:0]  ram_write_data,
    output logic [axi_mem_pkg::strb_width-1:0]  ram_write_strb
);

    localparam int index_low = axi_mem_pkg::offset_width;
    localparam int index_high = index_low + mem_index_width - 1;

    localparam logic [1:0] state_idle = 2'd0;
    localparam logic [1:0] state_data = 2'd1;
    localparam logic [1:0] state_response = 2'd2;

    logic [1:0] state;

    // byte offset and bits above the RAM are dropped
    wire unused_addr_bits = ^{awaddr[axi_mem_pkg::addr_width-1:index_high+1],
                              awaddr[index_low-1:0]};

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= state_idle;
        end else begin
            case (state)
                state_idle: begin
                    if (awvalid) begin
                        state <= state_data;
                    end
                end
                state_data: begin
                    if (wvalid) begin
                        state <= state_response;
                    end
                end
                state_response: begin
                    if (bready) begin
                        state <= state_idle;
                    end
                end
                default: begin
                    state <= state_idle;
                end
            endcase
        end
    end

    // word index latched on the aw handshake
    always_ff @(posedge clock) begin
        if (awvalid && awready) begin
            ram_write_index <= awaddr[index_high:index_low];
        end
    end

    assign awready = (state == state_idle);
    assign wready = (state == state_data);
    assign bvalid = (state == state_response);

    assign ram_write_enable = wvalid && wready;
    assign ram_write_data = wdata;
    assign ram_write_strb = wstrb;

    // response held until the master takes it
    bvalid_held: assert property (@(posedge clock) disable iff (reset)
        bvalid && !bready |=> bvalid);

    // no data beat accepted while a response is pending
    no_data_in_response: assert property (@(posedge clock) disable iff (reset)
        !(wready && bvalid));

endmodule

`default_nettype wire
